/* exu_cfg.svh */
// RV32 only; a different EXU_XLEN also changes the divider latency through EXU_DIV_STEPS
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// data and address width
`define EXU_XLEN 32

// register index width
`define EXU_REG_AW 5

// op code width, shared by all unit op enums
`define EXU_OP_W 4

// one quotient bit per divider iteration
`define EXU_DIV_STEPS `EXU_XLEN

`endif

/* exu_pkg.sv */
// op codes are local to this core and are not the RISC-V funct fields
`include "exu_cfg.svh"

package exu_pkg;

    // target unit of an issued instruction
    typedef enum logic [1:0] {
        EXU_ALU    = 2'd0,
        EXU_BRANCH = 2'd1,
        EXU_DIV    = 2'd2
    } exu_class_e;

    typedef enum logic [`EXU_OP_W-1:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_LUI   = 4'd10,
        ALU_AUIPC = 4'd11,
        ALU_LINK  = 4'd12
    } alu_op_e;

    // jump codes sit above every ALU code so the ALU treats them as LINK
    typedef enum logic [`EXU_OP_W-1:0] {
        BR_BEQ  = 4'd0,
        BR_BNE  = 4'd1,
        BR_BLT  = 4'd2,
        BR_BGE  = 4'd3,
        BR_BLTU = 4'd4,
        BR_BGEU = 4'd5,
        BR_JAL  = 4'd13,
        BR_JALR = 4'd14
    } br_op_e;

    typedef enum logic [`EXU_OP_W-1:0] {
        DIV_DIV  = 4'd0,
        DIV_DIVU = 4'd1,
        DIV_REM  = 4'd2,
        DIV_REMU = 4'd3
    } div_op_e;

endpackage

/* exu_div_if.sv */
// one divide in flight at a time; the result has no ready and must be taken on the res_valid pulse
`timescale 1ns/1ns
`include "exu_cfg.svh"

interface exu_div_if
    import exu_pkg::*;
();
    // request, valid/ready
    logic                   req_valid;
    logic                   req_ready;
    div_op_e                op;
    logic [`EXU_XLEN-1:0]   dividend;
    logic [`EXU_XLEN-1:0]   divisor;
    logic [`EXU_REG_AW-1:0] rd;

    // result, single cycle pulse
    logic                   res_valid;
    logic [`EXU_XLEN-1:0]   res_data;
    logic [`EXU_REG_AW-1:0] res_rd;

    modport dispatch (output req_valid, op, dividend, divisor, rd, input req_ready);
    modport divider (input req_valid, op, dividend, divisor, rd,
                     output req_ready, res_valid, res_data, res_rd);
    modport sink (input res_valid, res_data, res_rd);
endinterface

/* exu_dispatch.sv */
// issue stalls for every class while a divide runs; use_imm_i is ignored for branches
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_dispatch
    import exu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  exu_class_e             issue_class_i,
    input  logic [`EXU_OP_W-1:0]   issue_op_i,
    input  logic [`EXU_XLEN-1:0]   pc_i,
    input  logic [`EXU_XLEN-1:0]   rs1_data_i,
    input  logic [`EXU_XLEN-1:0]   rs2_data_i,
    input  logic [`EXU_XLEN-1:0]   imm_i,
    input  logic                   use_imm_i,
    input  logic [`EXU_REG_AW-1:0] rd_i,
    output logic                   alu_go_o,
    output logic                   bru_go_o,
    output logic [`EXU_OP_W-1:0]   op_o,
    output logic [`EXU_XLEN-1:0]   op1_o,
    output logic [`EXU_XLEN-1:0]   op2_o,
    output logic [`EXU_XLEN-1:0]   pc_o,
    output logic [`EXU_XLEN-1:0]   imm_o,
    output logic [`EXU_REG_AW-1:0] rd_o,
    exu_div_if.dispatch            div
);
    logic accept;
    logic is_jump;

    // divider idle means nothing older is pending, so any class may go
    assign issue_ready_o = div.req_ready;
    assign accept        = issue_valid_i && issue_ready_o;

    assign is_jump = (issue_class_i == EXU_BRANCH) &&
                     ((issue_op_i == BR_JAL) || (issue_op_i == BR_JALR));

    // jumps also start the ALU so the link value gets written
    assign alu_go_o = accept && ((issue_class_i == EXU_ALU) || is_jump);
    assign bru_go_o = accept && (issue_class_i == EXU_BRANCH);

    // operand select, branches always compare rs1 with rs2
    assign op_o  = issue_op_i;
    assign op1_o = rs1_data_i;
    assign op2_o = (use_imm_i && (issue_class_i != EXU_BRANCH)) ? imm_i : rs2_data_i;
    assign pc_o  = pc_i;
    assign imm_o = imm_i;
    assign rd_o  = rd_i;

    // valid does not wait for ready
    assign div.req_valid = issue_valid_i && (issue_class_i == EXU_DIV);
    assign div.op        = div_op_e'(issue_op_i);
    assign div.dividend  = rs1_data_i;
    assign div.divisor   = op2_o;
    assign div.rd        = rd_i;

    // one unit per accepted instruction, the jump link write rides along with the branch unit
    a_one_unit: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({alu_go_o && !bru_go_o, bru_go_o, div.req_valid && div.req_ready}));

endmodule

/* exu_alu.sv */
// writes one cycle after go_i; any op code above AUIPC returns the link address pc + 4
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_alu
    import exu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   go_i,
    input  alu_op_e                op_i,
    input  logic [`EXU_XLEN-1:0]   op1_i,
    input  logic [`EXU_XLEN-1:0]   op2_i,
    input  logic [`EXU_XLEN-1:0]   pc_i,
    input  logic [`EXU_XLEN-1:0]   imm_i,
    input  logic [`EXU_REG_AW-1:0] rd_i,
    output logic                   we_o,
    output logic [`EXU_REG_AW-1:0] waddr_o,
    output logic [`EXU_XLEN-1:0]   wdata_o
);
    logic [4:0]           shamt;
    logic [`EXU_XLEN-1:0] result;

    assign shamt = op2_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:   result = op1_i + op2_i;
            ALU_SUB:   result = op1_i - op2_i;
            ALU_SLL:   result = op1_i << shamt;
            ALU_SLT:   result = `EXU_XLEN'($signed(op1_i) < $signed(op2_i));
            ALU_SLTU:  result = `EXU_XLEN'(op1_i < op2_i);
            ALU_XOR:   result = op1_i ^ op2_i;
            ALU_SRL:   result = op1_i >> shamt;
            ALU_SRA:   result = $signed(op1_i) >>> shamt;
            ALU_OR:    result = op1_i | op2_i;
            ALU_AND:   result = op1_i & op2_i;
            ALU_LUI:   result = imm_i;
            ALU_AUIPC: result = pc_i + imm_i;
            // LINK and the jump codes from the dispatcher
            default:   result = pc_i + `EXU_XLEN'(4);
        endcase
    end

    // x0 is never written
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            we_o <= 1'b0;
        end else begin
            we_o <= go_i && (rd_i != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (go_i) begin
            waddr_o <= rd_i;
            wdata_o <= result;
        end
    end

endmodule

/* exu_bru.sv */
// jump_addr_o is only meaningful while jump_flag_o is high
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_bru
    import exu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 go_i,
    input  br_op_e               op_i,
    input  logic [`EXU_XLEN-1:0] rs1_i,
    input  logic [`EXU_XLEN-1:0] rs2_i,
    input  logic [`EXU_XLEN-1:0] pc_i,
    input  logic [`EXU_XLEN-1:0] imm_i,
    output logic                 jump_flag_o,
    output logic [`EXU_XLEN-1:0] jump_addr_o
);
    logic                 rs_eq;
    logic                 rs_lt;
    logic                 rs_ltu;
    logic                 taken;
    logic [`EXU_XLEN-1:0] target;

    assign rs_eq  = (rs1_i == rs2_i);
    assign rs_lt  = ($signed(rs1_i) < $signed(rs2_i));
    assign rs_ltu = (rs1_i < rs2_i);

    always_comb begin
        case (op_i)
            BR_BEQ:  taken = rs_eq;
            BR_BNE:  taken = !rs_eq;
            BR_BLT:  taken = rs_lt;
            BR_BGE:  taken = !rs_lt;
            BR_BLTU: taken = rs_ltu;
            BR_BGEU: taken = !rs_ltu;
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr target drops bit 0
    assign target = (op_i == BR_JALR) ? ((rs1_i + imm_i) & ~`EXU_XLEN'(1)) : (pc_i + imm_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            jump_flag_o <= 1'b0;
        end else begin
            jump_flag_o <= go_i && taken;
        end
    end

    always_ff @(posedge clk) begin
        if (go_i && taken) begin
            jump_addr_o <= target;
        end
    end

endmodule

/* exu_div.sv */
// fixed latency of EXU_DIV_STEPS + 2 cycles; a new request is refused until the result pulses
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_div
    import exu_pkg::*;
(
    input logic        clk,
    input logic        rst_n_i,
    exu_div_if.divider div
);
    localparam int CNT_W = $clog2(`EXU_DIV_STEPS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CALC,
        S_FIX
    } state_e;

    state_e                 state;
    logic [CNT_W-1:0]       count;
    logic                   op_signed;
    logic                   dvd_neg;
    logic                   dvs_neg;
    logic [`EXU_XLEN-1:0]   dvd_mag;
    logic [`EXU_XLEN-1:0]   dvs_mag;
    logic [`EXU_XLEN-1:0]   quot;
    logic [`EXU_XLEN-1:0]   rem;
    logic [`EXU_XLEN-1:0]   dvs;
    logic                   neg_q;
    logic                   neg_r;
    logic                   want_rem;
    logic [`EXU_REG_AW-1:0] rd_q;
    logic [`EXU_XLEN:0]     rem_shift;
    logic [`EXU_XLEN:0]     diff;
    logic [`EXU_XLEN-1:0]   q_out;
    logic [`EXU_XLEN-1:0]   r_out;

    assign div.req_ready = (state == S_IDLE);

    // magnitudes, only signed ops look at the sign bits
    assign op_signed = (div.op == DIV_DIV) || (div.op == DIV_REM);
    assign dvd_neg   = op_signed && div.dividend[`EXU_XLEN-1];
    assign dvs_neg   = op_signed && div.divisor[`EXU_XLEN-1];
    assign dvd_mag   = dvd_neg ? -div.dividend : div.dividend;
    assign dvs_mag   = dvs_neg ? -div.divisor : div.divisor;

    // one restoring step, quot shifts the dividend out and the quotient in
    assign rem_shift = {rem, quot[`EXU_XLEN-1]};
    assign diff      = rem_shift - {1'b0, dvs};

    // divide by zero already gives all ones and rem = |dividend|, so the quotient sign is skipped;
    // min / -1 overflows to the min value, which is the required answer
    assign q_out = neg_q ? -quot : quot;
    assign r_out = neg_r ? -rem : rem;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state         <= S_IDLE;
            count         <= '0;
            div.res_valid <= 1'b0;
        end else begin
            div.res_valid <= (state == S_FIX);
            case (state)
                S_IDLE: begin
                    if (div.req_valid) begin
                        state <= S_CALC;
                        count <= '0;
                    end
                end
                S_CALC: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(`EXU_DIV_STEPS - 1)) begin
                        state <= S_FIX;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && div.req_valid) begin
            quot     <= dvd_mag;
            dvs      <= dvs_mag;
            rem      <= '0;
            neg_q    <= (dvd_neg ^ dvs_neg) && (div.divisor != '0);
            neg_r    <= dvd_neg;
            want_rem <= (div.op == DIV_REM) || (div.op == DIV_REMU);
            rd_q     <= div.rd;
        end else if (state == S_CALC) begin
            if (!diff[`EXU_XLEN]) begin
                rem  <= diff[`EXU_XLEN-1:0];
                quot <= {quot[`EXU_XLEN-2:0], 1'b1};
            end else begin
                rem  <= rem_shift[`EXU_XLEN-1:0];
                quot <= {quot[`EXU_XLEN-2:0], 1'b0};
            end
        end else if (state == S_FIX) begin
            div.res_data <= want_rem ? r_out : q_out;
            div.res_rd   <= rd_q;
        end
    end

    // busy for load plus all steps, then the result arrives as ready returns
    a_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        (div.req_valid && div.req_ready) |=>
            (!div.req_ready) [*(`EXU_DIV_STEPS + 1)] ##1 (div.res_valid && div.req_ready));

    a_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        div.res_valid |=> !div.res_valid);

endmodule

/* exu.sv */
// instructions must arrive pre-decoded; the divider stalls all issue until its writeback
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu
    import exu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,

    // issue
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  exu_class_e             issue_class_i,
    input  logic [`EXU_OP_W-1:0]   issue_op_i,
    input  logic [`EXU_XLEN-1:0]   pc_i,
    input  logic [`EXU_XLEN-1:0]   rs1_data_i,
    input  logic [`EXU_XLEN-1:0]   rs2_data_i,
    input  logic [`EXU_XLEN-1:0]   imm_i,
    input  logic                   use_imm_i,
    input  logic [`EXU_REG_AW-1:0] rd_i,

    // writeback
    output logic                   alu_we_o,
    output logic [`EXU_REG_AW-1:0] alu_waddr_o,
    output logic [`EXU_XLEN-1:0]   alu_wdata_o,
    output logic                   div_we_o,
    output logic [`EXU_REG_AW-1:0] div_waddr_o,
    output logic [`EXU_XLEN-1:0]   div_wdata_o,

    // control flow
    output logic                   jump_flag_o,
    output logic [`EXU_XLEN-1:0]   jump_addr_o,
    output logic                   hold_o
);
    logic                   alu_go;
    logic                   bru_go;
    logic [`EXU_OP_W-1:0]   disp_op;
    logic [`EXU_XLEN-1:0]   disp_op1;
    logic [`EXU_XLEN-1:0]   disp_op2;
    logic [`EXU_XLEN-1:0]   disp_pc;
    logic [`EXU_XLEN-1:0]   disp_imm;
    logic [`EXU_REG_AW-1:0] disp_rd;

    exu_div_if div_bus ();

    exu_dispatch u_dispatch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .issue_valid_i(issue_valid_i),
        .issue_ready_o(issue_ready_o),
        .issue_class_i(issue_class_i),
        .issue_op_i   (issue_op_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .imm_i        (imm_i),
        .use_imm_i    (use_imm_i),
        .rd_i         (rd_i),
        .alu_go_o     (alu_go),
        .bru_go_o     (bru_go),
        .op_o         (disp_op),
        .op1_o        (disp_op1),
        .op2_o        (disp_op2),
        .pc_o         (disp_pc),
        .imm_o        (disp_imm),
        .rd_o         (disp_rd),
        .div          (div_bus.dispatch)
    );

    exu_alu u_alu (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .go_i   (alu_go),
        .op_i   (alu_op_e'(disp_op)),
        .op1_i  (disp_op1),
        .op2_i  (disp_op2),
        .pc_i   (disp_pc),
        .imm_i  (disp_imm),
        .rd_i   (disp_rd),
        .we_o   (alu_we_o),
        .waddr_o(alu_waddr_o),
        .wdata_o(alu_wdata_o)
    );

    exu_bru u_bru (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .go_i       (bru_go),
        .op_i       (br_op_e'(disp_op)),
        .rs1_i      (disp_op1),
        .rs2_i      (disp_op2),
        .pc_i       (disp_pc),
        .imm_i      (disp_imm),
        .jump_flag_o(jump_flag_o),
        .jump_addr_o(jump_addr_o)
    );

    exu_div u_div (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .div    (div_bus.divider)
    );

    // divider result side, the sink view of the bus
    assign div_we_o    = div_bus.res_valid;
    assign div_waddr_o = div_bus.res_rd;
    assign div_wdata_o = div_bus.res_data;

    assign hold_o = !div_bus.req_ready;

endmodule

/* tb_exu.sv */
// needs concurrent assertions enabled; the divide model expects result and ready exactly 34 edges on
`timescale 1ns/1ns
`include "exu_cfg.svh"

module tb_exu
    import exu_pkg::*;
();
    typedef logic [`EXU_XLEN-1:0] word_t;

    localparam int unsigned SEED = 32'h03c381ad;
    localparam int N_REP      = 8;
    localparam int N_DIV      = 16;
    localparam int DIV_EDGES  = `EXU_DIV_STEPS + 2;
    // reset, alu and branch sweeps, all divides with the stalled one, a few idle gaps
    localparam int PLAN_CYCLES = 8 + 13 * N_REP + 8 * N_REP + (N_DIV + 1) * DIV_EDGES + 24;
    localparam int CYCLE_LIMIT = 2 * PLAN_CYCLES;

    logic                   clk;
    logic                   rst_n_i;
    logic                   issue_valid_i;
    logic                   issue_ready_o;
    exu_class_e             issue_class_i;
    logic [`EXU_OP_W-1:0]   issue_op_i;
    word_t                  pc_i;
    word_t                  rs1_data_i;
    word_t                  rs2_data_i;
    word_t                  imm_i;
    logic                   use_imm_i;
    logic [`EXU_REG_AW-1:0] rd_i;
    logic                   alu_we_o;
    logic [`EXU_REG_AW-1:0] alu_waddr_o;
    word_t                  alu_wdata_o;
    logic                   div_we_o;
    logic [`EXU_REG_AW-1:0] div_waddr_o;
    word_t                  div_wdata_o;
    logic                   jump_flag_o;
    word_t                  jump_addr_o;
    logic                   hold_o;

    // reference model state
    logic                   accept;
    logic                   is_jump;
    logic                   alu_go;
    logic                   div_go;
    word_t                  opnd2;
    logic                   exp_hold;
    logic                   exp_alu_we;
    logic [`EXU_REG_AW-1:0] exp_alu_addr;
    word_t                  exp_alu_data;
    logic                   exp_jump;
    word_t                  exp_jaddr;
    logic                   exp_div_we;
    logic [`EXU_REG_AW-1:0] exp_div_addr;
    word_t                  exp_div_data;
    int                     div_left;
    int                     alu_writes;

    int      err_cnt;
    int      err_mark;
    int      n_tests;
    int      cycles;
    int      rep;
    int      start_writes;
    word_t   a;
    word_t   b;
    alu_op_e aop;
    br_op_e  bop;
    div_op_e dop;

    exu i_exu (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t alu_model(alu_op_e op, word_t x, word_t y, word_t pc, word_t imm);
        word_t res;
        case (op)
            ALU_ADD:   res = x + y;
            ALU_SUB:   res = x - y;
            ALU_SLL:   res = x << y[4:0];
            ALU_SLT:   res = ($signed(x) < $signed(y)) ? 1 : 0;
            ALU_SLTU:  res = (x < y) ? 1 : 0;
            ALU_XOR:   res = x ^ y;
            ALU_SRL:   res = x >> y[4:0];
            ALU_SRA:   res = word_t'($signed(x) >>> y[4:0]);
            ALU_OR:    res = x | y;
            ALU_AND:   res = x & y;
            ALU_LUI:   res = imm;
            ALU_AUIPC: res = pc + imm;
            default:   res = pc + 4;
        endcase
        return res;
    endfunction

    function automatic logic br_taken(br_op_e op, word_t x, word_t y);
        logic t;
        case (op)
            BR_BEQ:  t = (x == y);
            BR_BNE:  t = (x != y);
            BR_BLT:  t = ($signed(x) < $signed(y));
            BR_BGE:  t = ($signed(x) >= $signed(y));
            BR_BLTU: t = (x < y);
            BR_BGEU: t = (x >= y);
            // jal and jalr always jump
            default: t = 1'b1;
        endcase
        return t;
    endfunction

    function automatic word_t br_target(br_op_e op, word_t x, word_t pc, word_t imm);
        word_t sum;
        sum = (op == BR_JALR) ? x + imm : pc + imm;
        if (op == BR_JALR) begin
            sum[0] = 1'b0;
        end
        return sum;
    endfunction

    function automatic word_t div_model(div_op_e op, word_t x, word_t y);
        logic  sgn;
        word_t q;
        word_t r;
        sgn = (op == DIV_DIV) || (op == DIV_REM);
        if (y == '0) begin
            q = '1;
            r = x;
        end else if (sgn && (x == {1'b1, {(`EXU_XLEN-1){1'b0}}}) && (y == '1)) begin
            q = x;
            r = '0;
        end else if (sgn) begin
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end else begin
            q = x / y;
            r = x % y;
        end
        return ((op == DIV_REM) || (op == DIV_REMU)) ? r : q;
    endfunction

    assign accept  = issue_valid_i && !exp_hold;
    assign is_jump = (issue_class_i == EXU_BRANCH) &&
                     ((issue_op_i == BR_JAL) || (issue_op_i == BR_JALR));
    assign alu_go  = accept && ((issue_class_i == EXU_ALU) || is_jump);
    assign div_go  = accept && (issue_class_i == EXU_DIV);
    assign opnd2   = use_imm_i ? imm_i : rs2_data_i;

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exp_hold   <= 1'b0;
            exp_alu_we <= 1'b0;
            exp_jump   <= 1'b0;
            exp_div_we <= 1'b0;
            div_left   <= 0;
            alu_writes <= 0;
        end else begin
            exp_alu_we <= alu_go && (rd_i != '0);
            if (alu_go) begin
                exp_alu_addr <= rd_i;
                exp_alu_data <= is_jump ? pc_i + 4 :
                    alu_model(alu_op_e'(issue_op_i), rs1_data_i, opnd2, pc_i, imm_i);
            end
            exp_jump <= accept && (issue_class_i == EXU_BRANCH) &&
                        br_taken(br_op_e'(issue_op_i), rs1_data_i, rs2_data_i);
            if (accept && (issue_class_i == EXU_BRANCH)) begin
                exp_jaddr <= br_target(br_op_e'(issue_op_i), rs1_data_i, pc_i, imm_i);
            end
            // edges left until the divide result is due
            exp_div_we <= (div_left == 1);
            exp_hold   <= div_go || (div_left > 1);
            if (div_go) begin
                div_left     <= DIV_EDGES - 1;
                exp_div_addr <= rd_i;
                exp_div_data <= div_model(div_op_e'(issue_op_i), rs1_data_i, opnd2);
            end else if (div_left != 0) begin
                div_left <= div_left - 1;
            end
            if (alu_we_o) begin
                alu_writes <= alu_writes + 1;
            end
        end
    end

    task automatic report_mismatch(input string name, input word_t exp, input word_t got);
        $display("ERR %s expected %h actual %h", name, exp, got);
        err_cnt++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    a_reset: assert property (@(posedge clk)
        !rst_n_i |-> (!alu_we_o && !div_we_o && !jump_flag_o && !hold_o && issue_ready_o))
        else note_failure("outputs left their reset values while rst_n_i was low");
    a_ready: assert property (@(posedge clk) disable iff (!rst_n_i) issue_ready_o == !exp_hold)
        else report_mismatch("issue_ready_o", word_t'(!$sampled(exp_hold)),
                             word_t'($sampled(issue_ready_o)));
    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i) hold_o == exp_hold)
        else report_mismatch("hold_o", word_t'($sampled(exp_hold)), word_t'($sampled(hold_o)));
    a_alu_we: assert property (@(posedge clk) disable iff (!rst_n_i) alu_we_o == exp_alu_we)
        else report_mismatch("alu_we_o", word_t'($sampled(exp_alu_we)),
                             word_t'($sampled(alu_we_o)));
    a_alu_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
        alu_we_o |-> alu_waddr_o == exp_alu_addr)
        else report_mismatch("alu_waddr_o", word_t'($sampled(exp_alu_addr)),
                             word_t'($sampled(alu_waddr_o)));
    a_alu_data: assert property (@(posedge clk) disable iff (!rst_n_i)
        alu_we_o |-> alu_wdata_o == exp_alu_data)
        else report_mismatch("alu_wdata_o", $sampled(exp_alu_data), $sampled(alu_wdata_o));
    a_jump: assert property (@(posedge clk) disable iff (!rst_n_i) jump_flag_o == exp_jump)
        else report_mismatch("jump_flag_o", word_t'($sampled(exp_jump)),
                             word_t'($sampled(jump_flag_o)));
    a_jaddr: assert property (@(posedge clk) disable iff (!rst_n_i)
        jump_flag_o |-> jump_addr_o == exp_jaddr)
        else report_mismatch("jump_addr_o", $sampled(exp_jaddr), $sampled(jump_addr_o));
    a_div_we: assert property (@(posedge clk) disable iff (!rst_n_i) div_we_o == exp_div_we)
        else report_mismatch("div_we_o", word_t'($sampled(exp_div_we)),
                             word_t'($sampled(div_we_o)));
    a_div_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
        div_we_o |-> div_waddr_o == exp_div_addr)
        else report_mismatch("div_waddr_o", word_t'($sampled(exp_div_addr)),
                             word_t'($sampled(div_waddr_o)));
    a_div_data: assert property (@(posedge clk) disable iff (!rst_n_i)
        div_we_o |-> div_wdata_o == exp_div_data)
        else report_mismatch("div_wdata_o", $sampled(exp_div_data), $sampled(div_wdata_o));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped accepting or finishing", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // holds the instruction until the edge that accepts it
    task automatic issue_instr(input exu_class_e cls, input logic [`EXU_OP_W-1:0] op,
                               input word_t rs1, input word_t rs2, input word_t imm,
                               input logic use_imm, input logic [`EXU_REG_AW-1:0] rd);
        logic taken_up;
        issue_valid_i = 1'b1;
        issue_class_i = cls;
        issue_op_i    = op;
        rs1_data_i    = rs1;
        rs2_data_i    = rs2;
        imm_i         = imm;
        use_imm_i     = use_imm;
        rd_i          = rd;
        pc_i          = $urandom & ~word_t'(3);
        taken_up      = 1'b0;
        // ready has settled 1 ns after the edge
        while (!taken_up) begin
            taken_up = issue_ready_o;
            @(posedge clk);
            #1;
        end
        issue_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (hold_o) begin
            @(posedge clk);
            #1;
        end
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, err_cnt - err_mark);
        err_mark = err_cnt;
        n_tests++;
    endtask

    initial begin
        rst_n_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_class_i = EXU_ALU;
        issue_op_i    = '0;
        pc_i          = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        imm_i         = '0;
        use_imm_i     = 1'b0;
        rd_i          = '0;
        err_cnt       = 0;
        err_mark      = 0;
        n_tests       = 0;
        cycles        = 0;
        void'($urandom(SEED));
        #1 rst_n_i = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n_i = 1'b1;
        wait_idle();
        end_test("reset");

        // first pass of each op goes to x0
        aop = aop.first();
        repeat (aop.num()) begin
            for (rep = 0; rep < N_REP; rep++) begin
                issue_instr(EXU_ALU, aop, $urandom, $urandom, $urandom, 1'($urandom),
                            (rep == 0) ? '0 : `EXU_REG_AW'($urandom));
            end
            aop = aop.next();
        end
        wait_idle();
        end_test("alu");

        bop = bop.first();
        repeat (bop.num()) begin
            for (rep = 0; rep < N_REP; rep++) begin
                a = $urandom;
                // equal pairs on odd passes
                b = rep[0] ? a : word_t'($urandom);
                issue_instr(EXU_BRANCH, bop, a, b, $urandom, 1'($urandom),
                            `EXU_REG_AW'($urandom));
            end
            bop = bop.next();
        end
        wait_idle();
        end_test("branch");

        issue_instr(EXU_DIV, DIV_DIV, 32'd7, 32'd0, '0, 1'b0, 5'd1);
        issue_instr(EXU_DIV, DIV_REMU, 32'hdead_beef, 32'd0, '0, 1'b0, 5'd2);
        issue_instr(EXU_DIV, DIV_DIV, 32'h8000_0000, 32'hffff_ffff, '0, 1'b0, 5'd3);
        issue_instr(EXU_DIV, DIV_REM, 32'h8000_0000, 32'hffff_ffff, '0, 1'b0, 5'd4);
        issue_instr(EXU_DIV, DIV_REM, 32'hffff_fff9, 32'd2, '0, 1'b0, 5'd5);
        issue_instr(EXU_DIV, DIV_DIVU, 32'hffff_fff9, 32'd2, '0, 1'b0, 5'd6);
        dop = dop.first();
        for (rep = 0; rep < N_DIV - 6; rep++) begin
            issue_instr(EXU_DIV, dop, $urandom, word_t'($signed($urandom) >>> (rep * 3)),
                        '0, 1'b0, `EXU_REG_AW'($urandom));
            dop = dop.next();
        end
        wait_idle();
        end_test("divide");

        // alu ops queue up behind a running divide
        start_writes = alu_writes;
        issue_instr(EXU_DIV, DIV_DIVU, $urandom, 32'd3, '0, 1'b0, 5'd9);
        for (rep = 0; rep < 4; rep++) begin
            issue_instr(EXU_ALU, ALU_ADD, $urandom, word_t'(rep), '0, 1'b0,
                        `EXU_REG_AW'(rep + 10));
        end
        wait_idle();
        a_bp_writes: assert (alu_writes - start_writes == 4)
            else note_failure("ALU writes after the stalled divide differ from the four issued");
        end_test("back-pressure");

        $display("summary: %0d tests, %0d errors", n_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
exu_pkg.sv
exu_div_if.sv
exu_dispatch.sv
exu_alu.sv
exu_bru.sv
exu_div.sv
exu.sv
tb_exu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_exu -f vlog.f -o sim_exu
	./obj_dir/sim_exu | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
